// File: hw/exu_pkg.sv
package exu_pkg;

    // datapath widths
    localparam int XLEN = 64;
    localparam int WORD_W = XLEN / 2;
    typedef logic [XLEN-1:0] xlen_t;

    localparam int REG_ADDR_W = 5;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    localparam int FUNCT3_W = 3;
    typedef logic [FUNCT3_W-1:0] funct3_t;

    // one-hot instruction class from decode
    localparam int OP_TYPE_W = 9;
    typedef logic [OP_TYPE_W-1:0] op_type_t;

    localparam int OP_LUI    = 0;
    localparam int OP_AUIPC  = 1;
    localparam int OP_JAL    = 2;
    localparam int OP_JALR   = 3;
    localparam int OP_BRANCH = 4;
    localparam int OP_IMM    = 5;
    localparam int OP_REG    = 6;
    localparam int OP_IMM_W  = 7;
    localparam int OP_REG_W  = 8;

    // pc step, no compressed instructions
    localparam int INST_BYTES = 4;

    // shift amount widths, 64-bit and word forms
    localparam int SHAMT_W      = 6;
    localparam int SHAMT_W_WORD = 5;

    // alu operation codes
    localparam int ALU_OP_W = 4;
    typedef logic [ALU_OP_W-1:0] alu_op_t;

    localparam alu_op_t ALU_ADD  = 4'd0;
    localparam alu_op_t ALU_SUB  = 4'd1;
    localparam alu_op_t ALU_SLT  = 4'd2;
    localparam alu_op_t ALU_SLTU = 4'd3;
    localparam alu_op_t ALU_AND  = 4'd4;
    localparam alu_op_t ALU_OR   = 4'd5;
    localparam alu_op_t ALU_XOR  = 4'd6;
    localparam alu_op_t ALU_SLL  = 4'd7;
    localparam alu_op_t ALU_SRL  = 4'd8;
    localparam alu_op_t ALU_SRA  = 4'd9;

    // funct3 of op / op-imm
    localparam funct3_t F3_ADD  = 3'b000;
    localparam funct3_t F3_SLL  = 3'b001;
    localparam funct3_t F3_SLT  = 3'b010;
    localparam funct3_t F3_SLTU = 3'b011;
    localparam funct3_t F3_XOR  = 3'b100;
    localparam funct3_t F3_SRL  = 3'b101;
    localparam funct3_t F3_OR   = 3'b110;
    localparam funct3_t F3_AND  = 3'b111;

    // funct3 of branches
    localparam funct3_t F3_BEQ  = 3'b000;
    localparam funct3_t F3_BNE  = 3'b001;
    localparam funct3_t F3_BLT  = 3'b100;
    localparam funct3_t F3_BGE  = 3'b101;
    localparam funct3_t F3_BLTU = 3'b110;
    localparam funct3_t F3_BGEU = 3'b111;

    // imm[10] is funct7 bit 5 for reg ops, imm[12] the branch offset sign
    localparam int IMM_SUB_BIT  = 10;
    localparam int IMM_SIGN_BIT = 12;

    // instruction handed over by decode
    typedef struct packed {
        xlen_t     pc;
        op_type_t  op_type;
        funct3_t   funct3;
        reg_addr_t rd;
        reg_addr_t rs1;
        reg_addr_t rs2;
        xlen_t     src_a;
        xlen_t     src_b;
        xlen_t     imm;
    } id_ex_t;

    // register write of a later stage
    typedef struct packed {
        logic      writing;
        reg_addr_t rd;
        xlen_t     data;
    } bypass_t;

    // result toward mem
    typedef struct packed {
        xlen_t     pc;
        reg_addr_t rd;
        xlen_t     result;
    } ex_mem_t;

endpackage

// File: hw/exu_stage_reg.sv
`timescale 1ns/1ps

module exu_stage_reg (
    input  logic            clk,
    input  logic            arst_n,
    input  logic            load,
    input  logic            flush,
    input  logic            in_valid,
    input  exu_pkg::id_ex_t in_instr,
    output logic            out_valid,
    output exu_pkg::id_ex_t out_instr
);
    import exu_pkg::*;

    id_ex_t instr_q;
    logic   valid_q;

    // valid bit of the instruction in execute
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_q <= 1'b0;
        end else if (flush) begin
            // wrong-path instruction, drop it
            valid_q <= 1'b0;
        end else if (load) begin
            valid_q <= in_valid;
        end
    end

    // instruction contents
    // flush wins over a load in the same cycle
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            instr_q <= '0;
        end else if (flush) begin
            instr_q <= '0;
        end else if (load) begin
            instr_q <= in_instr;
        end
    end

    // mem side back-pressure keeps load low, so both regs hold

    assign out_valid = valid_q;
    assign out_instr = instr_q;

endmodule

// File: hw/exu_forward.sv
`timescale 1ns/1ps

module exu_forward (
    input  exu_pkg::id_ex_t  instr,
    input  exu_pkg::bypass_t bypass_mem,
    input  exu_pkg::bypass_t bypass_wb,
    output exu_pkg::xlen_t   src1,
    output exu_pkg::xlen_t   src2
);
    import exu_pkg::*;

    logic uses_rs2;

    // mem is younger than wb, so it is checked first
    function automatic xlen_t bypass_sel(
        input reg_addr_t rs,
        input xlen_t     decoded,
        input logic      enable,
        input bypass_t   mem,
        input bypass_t   wb
    );
        xlen_t value;
        value = decoded;
        // x0 reads as zero whatever a later stage claims
        if (enable && (rs != '0)) begin
            if (mem.writing && (mem.rd == rs)) begin
                value = mem.data;
            end else if (wb.writing && (wb.rd == rs)) begin
                value = wb.data;
            end
        end
        return value;
    endfunction

    // only these classes read rs2
    // the rs2 field of other formats is part of the immediate
    assign uses_rs2 = instr.op_type[OP_BRANCH] |
                      instr.op_type[OP_REG]    |
                      instr.op_type[OP_REG_W];

    // rs1 is read by every class that has it
    assign src1 = bypass_sel(instr.rs1, instr.src_a, 1'b1, bypass_mem, bypass_wb);

    assign src2 = bypass_sel(instr.rs2, instr.src_b, uses_rs2, bypass_mem, bypass_wb);

endmodule

// File: hw/exu_alu_ctrl.sv
`timescale 1ns/1ps

module exu_alu_ctrl (
    input  exu_pkg::id_ex_t  instr,
    input  exu_pkg::xlen_t   src1,
    input  exu_pkg::xlen_t   src2,
    output exu_pkg::alu_op_t op,
    output exu_pkg::xlen_t   operand_a,
    output exu_pkg::xlen_t   operand_b,
    output logic             word_op,
    output logic             word_shift_right
);
    import exu_pkg::*;

    logic  is_int;
    logic  is_reg;
    logic  is_shift;
    logic  uses_pc;
    logic  is_link;
    logic  uses_imm;
    xlen_t shamt_src;
    xlen_t shamt;

    // 64-bit arithmetic classes
    assign is_int  = instr.op_type[OP_IMM] | instr.op_type[OP_REG];
    // 32-bit arithmetic classes
    assign word_op = instr.op_type[OP_IMM_W] | instr.op_type[OP_REG_W];
    assign is_reg  = instr.op_type[OP_REG] | instr.op_type[OP_REG_W];

    assign is_shift = (is_int | word_op) &
                      ((instr.funct3 == F3_SLL) || (instr.funct3 == F3_SRL));

    // srlw / sraw / srliw / sraiw work on the upper half
    assign word_shift_right = word_op & (instr.funct3 == F3_SRL);

    assign uses_pc = instr.op_type[OP_AUIPC] | instr.op_type[OP_JAL] | instr.op_type[OP_JALR];
    assign is_link = instr.op_type[OP_JAL] | instr.op_type[OP_JALR];

    assign uses_imm = instr.op_type[OP_LUI] | instr.op_type[OP_AUIPC] |
                      instr.op_type[OP_IMM] | instr.op_type[OP_IMM_W];

    // operation select
    always_comb begin
        op = ALU_ADD;
        if (instr.op_type[OP_BRANCH]) begin
            // compare by subtraction
            op = ALU_SUB;
        end else if (is_int || word_op) begin
            case (instr.funct3)
                F3_ADD:  op = (is_reg && instr.imm[IMM_SUB_BIT]) ? ALU_SUB : ALU_ADD;
                F3_SLL:  op = ALU_SLL;
                F3_SRL:  op = instr.imm[IMM_SUB_BIT] ? ALU_SRA : ALU_SRL;
                // no word forms of these, word classes fall back to add
                F3_SLT:  op = is_int ? ALU_SLT : ALU_ADD;
                F3_SLTU: op = is_int ? ALU_SLTU : ALU_ADD;
                F3_XOR:  op = is_int ? ALU_XOR : ALU_ADD;
                F3_OR:   op = is_int ? ALU_OR : ALU_ADD;
                F3_AND:  op = is_int ? ALU_AND : ALU_ADD;
                default: op = ALU_ADD;
            endcase
        end
    end

    // shift amount from rs2 for reg ops, from imm otherwise
    assign shamt_src = is_reg ? src2 : instr.imm;
    assign shamt     = word_op ? xlen_t'(shamt_src[SHAMT_W_WORD-1:0])
                               : xlen_t'(shamt_src[SHAMT_W-1:0]);

    // operand a
    // word right shifts move the low word up so bit 63 is the word sign
    always_comb begin
        if (instr.op_type[OP_LUI]) begin
            operand_a = '0;
        end else if (uses_pc) begin
            operand_a = instr.pc;
        end else if (word_shift_right) begin
            operand_a = {src1[WORD_W-1:0], {WORD_W{1'b0}}};
        end else begin
            operand_a = src1;
        end
    end

    // operand b
    always_comb begin
        if (is_link) begin
            // link address is pc + 4
            operand_b = xlen_t'(INST_BYTES);
        end else if (is_shift) begin
            operand_b = shamt;
        end else if (uses_imm) begin
            operand_b = instr.imm;
        end else begin
            operand_b = src2;
        end
    end

endmodule

// File: hw/exu_alu.sv
`timescale 1ns/1ps

module exu_alu (
    input  exu_pkg::alu_op_t op,
    input  exu_pkg::xlen_t   operand_a,
    input  exu_pkg::xlen_t   operand_b,
    input  logic             word_op,
    input  logic             word_shift_right,
    output exu_pkg::xlen_t   result,
    output exu_pkg::xlen_t   raw_result
);
    import exu_pkg::*;

    logic [SHAMT_W-1:0] shamt;

    // ctrl already masks word shifts to 5 bits
    assign shamt = operand_b[SHAMT_W-1:0];

    // full 64-bit operation
    always_comb begin
        case (op)
            ALU_ADD:  raw_result = operand_a + operand_b;
            ALU_SUB:  raw_result = operand_a - operand_b;
            ALU_SLT:  raw_result = xlen_t'($signed(operand_a) < $signed(operand_b));
            ALU_SLTU: raw_result = xlen_t'(operand_a < operand_b);
            ALU_AND:  raw_result = operand_a & operand_b;
            ALU_OR:   raw_result = operand_a | operand_b;
            ALU_XOR:  raw_result = operand_a ^ operand_b;
            ALU_SLL:  raw_result = operand_a << shamt;
            ALU_SRL:  raw_result = operand_a >> shamt;
            ALU_SRA:  raw_result = xlen_t'($signed(operand_a) >>> shamt);
            // unused codes behave as add
            default:  raw_result = operand_a + operand_b;
        endcase
    end

    // word fix-up
    always_comb begin
        if (word_shift_right) begin
            // shifted word sits in the upper half
            result = {{WORD_W{raw_result[XLEN-1]}}, raw_result[XLEN-1:WORD_W]};
        end else if (word_op) begin
            // addw, subw, sllw and imm forms
            result = {{WORD_W{raw_result[WORD_W-1]}}, raw_result[WORD_W-1:0]};
        end else begin
            result = raw_result;
        end
    end

    // raw_result stays unadjusted for the branch compare

endmodule

// File: hw/exu_branch.sv
`timescale 1ns/1ps

module exu_branch (
    input  exu_pkg::id_ex_t instr,
    input  exu_pkg::xlen_t  src1,
    input  exu_pkg::xlen_t  src2,
    input  exu_pkg::xlen_t  diff,
    output logic            redirect,
    output exu_pkg::xlen_t  target
);
    import exu_pkg::*;

    logic  is_branch;
    logic  is_jalr;
    logic  sign_same;
    logic  eq;
    logic  lt;
    logic  ltu;
    logic  taken;
    logic  predict_taken;
    xlen_t base;
    xlen_t offset;

    assign is_branch = instr.op_type[OP_BRANCH];
    assign is_jalr   = instr.op_type[OP_JALR];

    // compare results from src1 - src2
    // no overflow when signs match, so diff sign decides
    assign sign_same = ~(src1[XLEN-1] ^ src2[XLEN-1]);
    assign eq        = (diff == '0);
    assign lt        = sign_same ? diff[XLEN-1] : src1[XLEN-1];
    assign ltu       = sign_same ? diff[XLEN-1] : src2[XLEN-1];

    always_comb begin
        case (instr.funct3)
            F3_BEQ:  taken = eq;
            F3_BNE:  taken = ~eq;
            F3_BLT:  taken = lt;
            F3_BGE:  taken = ~lt;
            F3_BLTU: taken = ltu;
            F3_BGEU: taken = ~ltu;
            default: taken = 1'b0;
        endcase
    end

    // static prediction, backward taken
    // fetch already follows it, so only a wrong guess redirects
    assign predict_taken = instr.imm[IMM_SIGN_BIT];

    // jalr target is never known early
    assign redirect = is_jalr | (is_branch & (taken != predict_taken));

    // one adder for all targets
    // mispredicted backward branch falls through to pc + 4
    // mispredicted forward branch goes to pc + imm
    assign base   = is_jalr ? src1 : instr.pc;
    assign offset = (!is_jalr && predict_taken) ? xlen_t'(INST_BYTES) : instr.imm;
    assign target = base + offset;

endmodule

// File: hw/exu_top.sv
`timescale 1ns/1ps

module exu_top (
    input  logic             clk,
    input  logic             arst_n,
    input  logic             valid_id_ex,
    input  exu_pkg::id_ex_t  id_ex,
    input  logic             ready_ex_mem,
    input  exu_pkg::bypass_t bypass_mem,
    input  exu_pkg::bypass_t bypass_wb,
    input  logic             branch_flush,
    output logic             ready_id_ex,
    output logic             valid_ex_mem,
    output exu_pkg::ex_mem_t ex_mem,
    output logic             pc_update,
    output exu_pkg::xlen_t   dnpc
);
    import exu_pkg::*;

    logic    ex_valid;
    id_ex_t  ex_instr;
    xlen_t   src1;
    xlen_t   src2;
    alu_op_t alu_op;
    xlen_t   operand_a;
    xlen_t   operand_b;
    logic    word_op;
    logic    word_shift_right;
    xlen_t   alu_result;
    xlen_t   alu_raw;
    logic    redirect;

    // no multi-cycle ops, the stage only stalls for mem
    assign ready_id_ex = ready_ex_mem;

    exu_stage_reg u_stage_reg (
        .clk       (clk),
        .arst_n    (arst_n),
        .load      (ready_id_ex),
        .flush     (branch_flush),
        .in_valid  (valid_id_ex),
        .in_instr  (id_ex),
        .out_valid (ex_valid),
        .out_instr (ex_instr)
    );

    exu_forward u_forward (
        .instr      (ex_instr),
        .bypass_mem (bypass_mem),
        .bypass_wb  (bypass_wb),
        .src1       (src1),
        .src2       (src2)
    );

    exu_alu_ctrl u_alu_ctrl (
        .instr            (ex_instr),
        .src1             (src1),
        .src2             (src2),
        .op               (alu_op),
        .operand_a        (operand_a),
        .operand_b        (operand_b),
        .word_op          (word_op),
        .word_shift_right (word_shift_right)
    );

    exu_alu u_alu (
        .op               (alu_op),
        .operand_a        (operand_a),
        .operand_b        (operand_b),
        .word_op          (word_op),
        .word_shift_right (word_shift_right),
        .result           (alu_result),
        .raw_result       (alu_raw)
    );

    // branch compare reuses the alu subtraction
    exu_branch u_branch (
        .instr    (ex_instr),
        .src1     (src1),
        .src2     (src2),
        .diff     (alu_raw),
        .redirect (redirect),
        .target   (dnpc)
    );

    // fires once, in the cycle the instruction leaves
    assign pc_update = ex_valid & ready_ex_mem & redirect;

    assign valid_ex_mem  = ex_valid;
    assign ex_mem.pc     = ex_instr.pc;
    assign ex_mem.rd     = ex_instr.rd;
    assign ex_mem.result = alu_result;

endmodule

// File: tb/tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen (
    output logic clk,
    output logic arst_n
);
    localparam int HALF_PERIOD  = 50;
    localparam int RESET_CYCLES = 4;

    // 100 ns period, free running
    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    // reset low for the first cycles, released on a rising edge
    initial begin
        arst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        arst_n <= 1'b1;
    end

endmodule

// File: tb/exu_tb.sv
`timescale 1ns/1ps

module exu_tb;
    import exu_pkg::*;

    localparam int TIMEOUT_CYCLES = 20;

    logic    clk;
    logic    arst_n;
    logic    valid_id_ex;
    id_ex_t  id_ex;
    logic    ready_ex_mem;
    bypass_t bypass_mem;
    bypass_t bypass_wb;
    logic    branch_flush;
    logic    ready_id_ex;
    logic    valid_ex_mem;
    ex_mem_t ex_mem;
    logic    pc_update;
    xlen_t   dnpc;

    string cur_test;
    int    errors;
    int    test_errors;
    int    checks;
    int    tests;

    tb_clk_gen u_clk_gen (
        .clk    (clk),
        .arst_n (arst_n)
    );

    exu_top u_dut (
        .clk          (clk),
        .arst_n       (arst_n),
        .valid_id_ex  (valid_id_ex),
        .id_ex        (id_ex),
        .ready_ex_mem (ready_ex_mem),
        .bypass_mem   (bypass_mem),
        .bypass_wb    (bypass_wb),
        .branch_flush (branch_flush),
        .ready_id_ex  (ready_id_ex),
        .valid_ex_mem (valid_ex_mem),
        .ex_mem       (ex_mem),
        .pc_update    (pc_update),
        .dnpc         (dnpc)
    );

    // rv64i op / op-imm results
    // b is rs2 or the immediate
    function automatic xlen_t ref_int(input logic is_reg, input funct3_t f3, input logic alt,
                                      input xlen_t a, input xlen_t b);
        case (f3)
            3'd0: return (is_reg && alt) ? a - b : a + b;
            3'd1: return a << b[5:0];
            3'd2: return xlen_t'($signed(a) < $signed(b));
            3'd3: return xlen_t'(a < b);
            3'd4: return a ^ b;
            3'd5: return alt ? xlen_t'($signed(a) >>> b[5:0]) : a >> b[5:0];
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    // word forms sign-extend their 32-bit result
    function automatic xlen_t ref_word(input logic is_reg, input funct3_t f3, input logic alt,
                                       input xlen_t a, input xlen_t b);
        logic [31:0] w;
        case (f3)
            3'd1: w = a[31:0] << b[4:0];
            3'd5: w = alt ? 32'($signed(a[31:0]) >>> b[4:0]) : a[31:0] >> b[4:0];
            default: w = (is_reg && alt) ? a[31:0] - b[31:0] : a[31:0] + b[31:0];
        endcase
        return {{32{w[31]}}, w};
    endfunction

    // branch outcome per funct3
    function automatic logic ref_taken(input funct3_t f3, input xlen_t a, input xlen_t b);
        case (f3)
            3'b000: return a == b;
            3'b001: return a != b;
            3'b100: return $signed(a) < $signed(b);
            3'b101: return $signed(a) >= $signed(b);
            3'b110: return a < b;
            default: return a >= b;
        endcase
    endfunction

    function automatic xlen_t rand64();
        return {$urandom, $urandom};
    endfunction

    // sign-extended 12-bit immediate
    function automatic xlen_t rand_imm12();
        logic [11:0] r;
        r = 12'($urandom);
        return {{52{r[11]}}, r};
    endfunction

    // word aligned pc in a ram-like range
    function automatic xlen_t rand_pc();
        return xlen_t'(32'h8000_0000) + xlen_t'(($urandom % 4096) * 4);
    endfunction

    function automatic id_ex_t make_instr(input int cls, input funct3_t f3,
                                          input reg_addr_t rs1, input reg_addr_t rs2,
                                          input xlen_t a, input xlen_t b,
                                          input xlen_t imm, input xlen_t pc);
        id_ex_t instr;
        instr = '0;
        instr.op_type[cls] = 1'b1;
        instr.pc     = pc;
        instr.funct3 = f3;
        instr.rd     = 5'd10;
        instr.rs1    = rs1;
        instr.rs2    = rs2;
        instr.src_a  = a;
        instr.src_b  = b;
        instr.imm    = imm;
        return instr;
    endfunction

    function automatic bypass_t make_bypass(input logic writing, input reg_addr_t rd,
                                            input xlen_t data);
        bypass_t bp;
        bp.writing = writing;
        bp.rd      = rd;
        bp.data    = data;
        return bp;
    endfunction

    task automatic start_test(input string name);
        cur_test    = name;
        test_errors = 0;
    endtask

    task automatic finish_test();
        tests++;
        if (test_errors == 0)
            $display("test %s passed", cur_test);
        else
            $display("test %s failed with %0d errors", cur_test, test_errors);
    endtask

    task automatic check_value(input string what, input xlen_t expected, input xlen_t actual);
        checks++;
        assert (actual == expected) else begin
            $display("[FAIL] %s %s: expected %h actual %h", cur_test, what, expected, actual);
            errors++;
            test_errors++;
        end
    endtask

    // samples valid_ex_mem on falling edges
    task automatic wait_for_valid(output logic got);
        int cycles;
        got    = 1'b0;
        cycles = 0;
        while (!got && cycles < TIMEOUT_CYCLES) begin
            @(negedge clk);
            got = valid_ex_mem;
            cycles++;
        end
        if (!got) begin
            $display("%s: valid_ex_mem did not rise within %0d cycles", cur_test,
                     TIMEOUT_CYCLES);
            errors++;
            test_errors++;
        end
    endtask

    // sends one instruction and waits for it at the output
    task automatic execute(input id_ex_t instr, input bypass_t mem, input bypass_t wb,
                           output logic got);
        @(posedge clk);
        valid_id_ex <= 1'b1;
        id_ex       <= instr;
        bypass_mem  <= mem;
        bypass_wb   <= wb;
        @(posedge clk);
        valid_id_ex <= 1'b0;
        wait_for_valid(got);
    endtask

    task automatic test_int_ops();
        id_ex_t instr;
        xlen_t  a;
        xlen_t  b;
        xlen_t  imm;
        logic   got;
        int     r;
        int     f;
        int     alt;
        start_test("int_ops");
        for (r = 0; r < 2; r++) begin
            for (f = 0; f < 8; f++) begin
                for (alt = 0; alt < 2; alt++) begin
                    a = rand64();
                    b = rand64();
                    // imm[10] is the funct7 sub/sra bit
                    if (r == 1)
                        imm = xlen_t'(alt) << IMM_SUB_BIT;
                    else if (f == 1 || f == 5)
                        imm = xlen_t'(6'($urandom)) | (xlen_t'(alt) << IMM_SUB_BIT);
                    else
                        imm = rand_imm12();
                    instr = make_instr((r == 1) ? OP_REG : OP_IMM, funct3_t'(f), 5'd1, 5'd2,
                                       a, b, imm, rand_pc());
                    // random destination register
                    instr.rd = reg_addr_t'($urandom);
                    execute(instr, '0, '0, got);
                    if (got) begin
                        check_value($sformatf("%s f3=%0d alt=%0d", (r == 1) ? "reg" : "imm",
                                              f, alt),
                                    ref_int(r == 1, funct3_t'(f), alt[0], a,
                                            (r == 1) ? b : imm),
                                    ex_mem.result);
                        check_value($sformatf("rd f3=%0d alt=%0d", f, alt),
                                    xlen_t'(instr.rd), xlen_t'(ex_mem.rd));
                    end
                end
            end
        end
        finish_test();
    endtask

    task automatic test_word_ops();
        id_ex_t  instr;
        funct3_t f3;
        xlen_t   a;
        xlen_t   b;
        xlen_t   imm;
        logic    got;
        int      r;
        int      k;
        int      alt;
        start_test("word_ops");
        for (r = 0; r < 2; r++) begin
            for (k = 0; k < 3; k++) begin
                for (alt = 0; alt < 2; alt++) begin
                    // add/sub, sll, srl/sra
                    f3 = (k == 0) ? 3'd0 : (k == 1) ? 3'd1 : 3'd5;
                    a  = rand64();
                    b  = rand64();
                    if (r == 1)
                        imm = xlen_t'(alt) << IMM_SUB_BIT;
                    else if (k != 0)
                        imm = xlen_t'(5'($urandom)) | (xlen_t'(alt) << IMM_SUB_BIT);
                    else
                        imm = rand_imm12();
                    instr = make_instr((r == 1) ? OP_REG_W : OP_IMM_W, f3, 5'd1, 5'd2,
                                       a, b, imm, rand_pc());
                    execute(instr, '0, '0, got);
                    if (got)
                        check_value($sformatf("%s f3=%0d alt=%0d", (r == 1) ? "regw" : "immw",
                                              f3, alt),
                                    ref_word(r == 1, f3, alt[0], a, (r == 1) ? b : imm),
                                    ex_mem.result);
                end
            end
        end
        finish_test();
    endtask

    task automatic test_forwarding();
        id_ex_t instr;
        xlen_t  a;
        xlen_t  b;
        xlen_t  m;
        xlen_t  w;
        xlen_t  imm;
        xlen_t  pc;
        logic   got;
        start_test("forwarding");
        a   = rand64();
        b   = rand64();
        m   = rand64();
        w   = rand64();
        imm = rand_imm12();
        pc  = rand_pc();
        // addi x10, x5, imm
        instr = make_instr(OP_IMM, 3'd0, 5'd5, 5'd0, a, '0, imm, pc);
        // both later stages hold x5 and the younger mem value wins
        execute(instr, make_bypass(1'b1, 5'd5, m), make_bypass(1'b1, 5'd5, w), got);
        if (got) check_value("mem over wb", m + imm, ex_mem.result);
        // mem busy with another register
        execute(instr, make_bypass(1'b1, 5'd6, m), make_bypass(1'b1, 5'd5, w), got);
        if (got) check_value("wb only", w + imm, ex_mem.result);
        // matching rd but no write
        execute(instr, make_bypass(1'b0, 5'd5, m), '0, got);
        if (got) check_value("no write", a + imm, ex_mem.result);
        // x0 never bypassed
        instr = make_instr(OP_IMM, 3'd0, 5'd0, 5'd0, a, '0, imm, pc);
        execute(instr, make_bypass(1'b1, 5'd0, m), make_bypass(1'b1, 5'd0, w), got);
        if (got) check_value("x0 decoded", a + imm, ex_mem.result);
        // the rs2 field of an imm op is no register read
        instr = make_instr(OP_IMM, 3'd0, 5'd3, 5'd9, a, b, imm, pc);
        execute(instr, make_bypass(1'b1, 5'd9, m), '0, got);
        if (got) check_value("imm op rs2", a + imm, ex_mem.result);
        // same rs2 on a reg op is forwarded
        instr = make_instr(OP_REG, 3'd0, 5'd3, 5'd9, a, b, '0, pc);
        execute(instr, make_bypass(1'b1, 5'd9, m), '0, got);
        if (got) check_value("reg op rs2", a + m, ex_mem.result);
        finish_test();
    endtask

    task automatic test_branches();
        id_ex_t  instr;
        funct3_t f3;
        xlen_t   a;
        xlen_t   b;
        xlen_t   off;
        xlen_t   imm;
        xlen_t   pc;
        logic    taken;
        logic    mispredict;
        logic    got;
        int      f;
        int      dir;
        int      p;
        start_test("branches");
        for (f = 0; f < 6; f++) begin
            for (dir = 0; dir < 2; dir++) begin
                for (p = 0; p < 3; p++) begin
                    // beq, bne, then blt..bgeu
                    f3  = funct3_t'((f < 2) ? f : f + 2);
                    a   = rand64();
                    b   = (p == 0) ? a : (p == 1) ? rand64() : a ^ (64'd1 << 63);
                    off = xlen_t'((($urandom % 1000) + 1) * 4);
                    imm = (dir == 1) ? -off : off;
                    pc  = rand_pc();
                    instr = make_instr(OP_BRANCH, f3, 5'd1, 5'd2, a, b, imm, pc);
                    execute(instr, '0, '0, got);
                    // backward predicted taken
                    taken      = ref_taken(f3, a, b);
                    mispredict = taken != (dir == 1);
                    if (got) begin
                        check_value($sformatf("pc_update f3=%0d dir=%0d", f3, dir),
                                    xlen_t'(mispredict), xlen_t'(pc_update));
                        if (mispredict)
                            check_value($sformatf("dnpc f3=%0d dir=%0d", f3, dir),
                                        taken ? pc + imm : pc + 64'd4, dnpc);
                    end
                end
            end
        end
        // jalr always redirects
        repeat (4) begin
            a   = rand64();
            imm = rand_imm12();
            pc  = rand_pc();
            instr = make_instr(OP_JALR, 3'd0, 5'd1, 5'd0, a, '0, imm, pc);
            execute(instr, '0, '0, got);
            if (got) begin
                check_value("jalr pc_update", 64'd1, xlen_t'(pc_update));
                check_value("jalr dnpc", a + imm, dnpc);
                check_value("jalr link", pc + 64'd4, ex_mem.result);
            end
        end
        finish_test();
    endtask

    task automatic test_upper_jal();
        id_ex_t      instr;
        logic [31:0] r;
        xlen_t       imm;
        xlen_t       pc;
        logic        got;
        start_test("lui_auipc_jal");
        repeat (3) begin
            r   = $urandom;
            imm = {{32{r[31]}}, r[31:12], 12'b0};
            pc  = rand_pc();
            instr = make_instr(OP_LUI, 3'd0, 5'd0, 5'd0, rand64(), '0, imm, pc);
            execute(instr, '0, '0, got);
            if (got) check_value("lui", imm, ex_mem.result);
            instr = make_instr(OP_AUIPC, 3'd0, 5'd0, 5'd0, rand64(), '0, imm, pc);
            execute(instr, '0, '0, got);
            if (got) check_value("auipc", pc + imm, ex_mem.result);
            // decode redirected jal already
            instr = make_instr(OP_JAL, 3'd0, 5'd0, 5'd0, rand64(), '0, rand_imm12(), pc);
            execute(instr, '0, '0, got);
            if (got) begin
                check_value("jal link", pc + 64'd4, ex_mem.result);
                check_value("jal pc_update", '0, xlen_t'(pc_update));
            end
        end
        finish_test();
    endtask

    task automatic test_stall_flush();
        id_ex_t first;
        id_ex_t second;
        xlen_t  a;
        xlen_t  imm;
        xlen_t  pc;
        logic   got;
        start_test("stall_flush");
        a      = rand64();
        imm    = rand_imm12();
        pc     = rand_pc();
        first  = make_instr(OP_JALR, 3'd0, 5'd1, 5'd0, a, '0, imm, pc);
        second = make_instr(OP_IMM, 3'd0, 5'd2, 5'd0, rand64(), '0, rand_imm12(), pc + 64'd4);
        // jalr enters and mem stalls right after
        @(posedge clk);
        valid_id_ex <= 1'b1;
        id_ex       <= first;
        bypass_mem  <= '0;
        bypass_wb   <= '0;
        @(posedge clk);
        valid_id_ex  <= 1'b0;
        ready_ex_mem <= 1'b0;
        wait_for_valid(got);
        // decode offers the next one during the stall
        @(posedge clk);
        valid_id_ex <= 1'b1;
        id_ex       <= second;
        repeat (3) begin
            @(negedge clk);
            check_value("ready_id_ex stalled", '0, xlen_t'(ready_id_ex));
            check_value("valid held", 64'd1, xlen_t'(valid_ex_mem));
            check_value("pc_update stalled", '0, xlen_t'(pc_update));
            check_value("result held", pc + 64'd4, ex_mem.result);
            check_value("pc held", pc, ex_mem.pc);
        end
        // mem takes it and the redirect fires now
        @(posedge clk);
        ready_ex_mem <= 1'b1;
        valid_id_ex  <= 1'b0;
        @(negedge clk);
        check_value("pc_update released", 64'd1, xlen_t'(pc_update));
        check_value("dnpc released", a + imm, dnpc);
        // back to back valid input that flush must still drop
        @(posedge clk);
        valid_id_ex <= 1'b1;
        id_ex       <= second;
        @(posedge clk);
        branch_flush <= 1'b1;
        wait_for_valid(got);
        if (got) check_value("before flush", second.src_a + second.imm, ex_mem.result);
        @(posedge clk);
        branch_flush <= 1'b0;
        valid_id_ex  <= 1'b0;
        @(negedge clk);
        check_value("valid after flush", '0, xlen_t'(valid_ex_mem));
        check_value("pc after flush", '0, ex_mem.pc);
        finish_test();
    endtask

    initial begin
        int cycles;
        void'($urandom(32'h6e0));
        errors       = 0;
        checks       = 0;
        tests        = 0;
        test_errors  = 0;
        cur_test     = "reset";
        valid_id_ex  = 1'b0;
        id_ex        = '0;
        ready_ex_mem = 1'b1;
        bypass_mem   = '0;
        bypass_wb    = '0;
        branch_flush = 1'b0;
        cycles       = 0;
        while (arst_n !== 1'b1 && cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        if (arst_n !== 1'b1) begin
            $display("reset was not released within %0d cycles", TIMEOUT_CYCLES);
            errors++;
        end else begin
            // idle outputs after reset
            @(negedge clk);
            check_value("valid after reset", '0, xlen_t'(valid_ex_mem));
            check_value("pc_update after reset", '0, xlen_t'(pc_update));
            test_int_ops();
            test_word_ops();
            test_forwarding();
            test_branches();
            test_upper_jal();
            test_stall_flush();
        end
        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// File: compile.f
hw/exu_pkg.sv
hw/exu_stage_reg.sv
hw/exu_forward.sv
hw/exu_alu_ctrl.sv
hw/exu_alu.sv
hw/exu_branch.sv
hw/exu_top.sv
tb/tb_clk_gen.sv
tb/exu_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the execute stage testbench with verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module exu_tb -f compile.f -o exu_sim \
    && ./obj_dir/exu_sim | tee /dev/stderr | grep -qx "Test OK" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
